//--- hdl/exu_cfg.svh
/*
  Execute unit configuration
  Data width, register index width, immediate field width
  and the number of outstanding-load entries
*/
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// Datapath
`define EXU_XLEN       32
`define EXU_RFIDX_W    5

// Immediate field width in the instruction word
`define EXU_IMM_W      14

// Loads that may be in flight at once
`define EXU_OITF_DEPTH 2

`endif

//--- hdl/exu_isa_pkg.sv
/*
  Execute unit instruction encoding
  Opcode and ALU operation codes, instruction word layout
  and the decoded-instruction bundle
*/
`include "exu_cfg.svh"

package exu_isa_pkg;

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_XOR  = 3'd3,
    OP_ADDI = 3'd4,
    OP_LOAD = 3'd5   // 6 and 7 are illegal
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_AND = 2'd2,
    ALU_XOR = 2'd3
  } alu_op_e;

  typedef struct packed {
    opcode_e                 opcode;
    logic [`EXU_RFIDX_W-1:0] rd;
    logic [`EXU_RFIDX_W-1:0] rs1;
    logic [`EXU_RFIDX_W-1:0] rs2;
    logic [`EXU_IMM_W-1:0]   imm;
  } instr_t;

  typedef struct packed {
    alu_op_e                 alu_op;
    logic                    is_load;
    logic                    use_imm;  // Immediate replaces rs2
    logic                    rs1en;
    logic                    rs2en;
    logic                    rdwen;
    logic [`EXU_RFIDX_W-1:0] rd;
    logic [`EXU_RFIDX_W-1:0] rs1;
    logic [`EXU_RFIDX_W-1:0] rs2;
    logic [`EXU_XLEN-1:0]    imm;      // Already sign extended
  } dec_info_t;

endpackage

//--- hdl/exu_pipe_pkg.sv
/*
  Execute unit pipeline payloads
  Bundles passed between dispatch, ALU, write-back
  and the external load unit
*/
`include "exu_cfg.svh"

package exu_pipe_pkg;

  ////////////////////
  // Dispatch to ALU

  typedef struct packed {
    exu_isa_pkg::alu_op_e    alu_op;
    logic [`EXU_XLEN-1:0]    opa;
    logic [`EXU_XLEN-1:0]    opb;   // rs2 or immediate
    logic [`EXU_RFIDX_W-1:0] rd;
  } alu_req_t;

  ////////////////////
  // Register file write

  typedef struct packed {
    logic [`EXU_RFIDX_W-1:0] rd;
    logic [`EXU_XLEN-1:0]    wdat;
  } wbck_t;

  ////////////////////
  // Load unit command

  typedef struct packed {
    logic [`EXU_XLEN-1:0] addr;  // rs1 + imm
  } lsu_cmd_t;

endpackage

//--- hdl/exu_regfile.sv
/*
  Integer register file
  32 entries, two combinational read ports and one write port
  Entry 0 is never written and always reads as zero
*/
`timescale 1ns/1ns
`include "exu_cfg.svh"

module exu_regfile (
  input  logic                    clk,
  input  logic                    i_arst_n,
  input  logic [`EXU_RFIDX_W-1:0] i_rs1idx,
  input  logic [`EXU_RFIDX_W-1:0] i_rs2idx,
  input  logic                    i_wen,
  input  exu_pipe_pkg::wbck_t     i_wbck,
  output logic [`EXU_XLEN-1:0]    o_rs1,
  output logic [`EXU_XLEN-1:0]    o_rs2
);

  localparam int NREGS = 1 << `EXU_RFIDX_W;

  logic [`EXU_XLEN-1:0] rf_q [NREGS];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wen && (i_wbck.rd != '0)) begin  // x0 writes dropped
      rf_q[i_wbck.rd] <= i_wbck.wdat;
    end
  end

  // Read ports
  assign o_rs1 = (i_rs1idx == '0) ? '0 : rf_q[i_rs1idx];
  assign o_rs2 = (i_rs2idx == '0) ? '0 : rf_q[i_rs2idx];

endmodule

//--- hdl/exu_decode.sv
/*
  Instruction decoder
  Splits the instruction word into register indices, a sign-extended
  immediate, the ALU operation and the operand and write enables
*/
`timescale 1ns/1ns
`include "exu_cfg.svh"

module exu_decode (
  input  exu_isa_pkg::instr_t    i_instr,
  output exu_isa_pkg::dec_info_t o_dec
);

  always_comb begin
    o_dec        = '0;
    o_dec.rd     = i_instr.rd;
    o_dec.rs1    = i_instr.rs1;
    o_dec.rs2    = i_instr.rs2;
    o_dec.imm    = {{(`EXU_XLEN-`EXU_IMM_W){i_instr.imm[`EXU_IMM_W-1]}}, i_instr.imm};
    o_dec.alu_op = exu_isa_pkg::ALU_ADD;

    case (i_instr.opcode)
      exu_isa_pkg::OP_ADD,
      exu_isa_pkg::OP_SUB,
      exu_isa_pkg::OP_AND,
      exu_isa_pkg::OP_XOR: begin
        o_dec.rs1en = 1'b1;
        o_dec.rs2en = 1'b1;
        o_dec.rdwen = 1'b1;
        // Low opcode bits line up with the ALU codes
        o_dec.alu_op = exu_isa_pkg::alu_op_e'(i_instr.opcode[1:0]);
      end
      exu_isa_pkg::OP_ADDI: begin
        o_dec.use_imm = 1'b1;
        o_dec.rs1en   = 1'b1;
        o_dec.rdwen   = 1'b1;
      end
      exu_isa_pkg::OP_LOAD: begin
        o_dec.is_load = 1'b1;
        o_dec.rs1en   = 1'b1;  // Base address only
        o_dec.rdwen   = 1'b1;
      end
      default: begin
        // Illegal opcodes leave every enable low
      end
    endcase
  end

endmodule

//--- hdl/exu_oitf.sv
/*
  Outstanding-instruction FIFO
  Ring of destination indices for loads in flight, with wrap-bit
  read and write pointer counters and a hazard match against
  the indices of the instruction being dispatched
*/
`timescale 1ns/1ns
`include "exu_cfg.svh"

module exu_oitf (
  input  logic                    clk,
  input  logic                    i_arst_n,
  input  logic                    i_alloc,
  input  logic [`EXU_RFIDX_W-1:0] i_alloc_rd,
  input  logic                    i_retire,
  input  logic [`EXU_RFIDX_W-1:0] i_chk_rs1,
  input  logic [`EXU_RFIDX_W-1:0] i_chk_rs2,
  input  logic [`EXU_RFIDX_W-1:0] i_chk_rd,
  input  logic                    i_chk_rs1en,
  input  logic                    i_chk_rs2en,
  input  logic                    i_chk_rden,
  output logic                    o_hazard,
  output logic [`EXU_RFIDX_W-1:0] o_head_rd,
  output logic                    o_full,
  output logic                    o_empty
);

  localparam int DEPTH = `EXU_OITF_DEPTH;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [AW:0]             wptr_q;
  logic [AW:0]             rptr_q;
  logic [`EXU_RFIDX_W-1:0] rd_q [DEPTH];
  logic [DEPTH-1:0]        ent_vld;
  logic [DEPTH-1:0]        ent_match;

  // Next pointer flips the wrap bit past the last entry
  function automatic logic [AW:0] ptr_inc(input logic [AW:0] ptr);
    logic [AW:0] nxt;
    if (ptr[AW-1:0] == AW'(DEPTH-1)) begin
      nxt = {~ptr[AW], {AW{1'b0}}};
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  ////////////////////
  // Pointer counters
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (i_alloc)  wptr_q <= ptr_inc(wptr_q);
      if (i_retire) rptr_q <= ptr_inc(rptr_q);
    end
  end

  always_ff @(posedge clk) begin
    if (i_alloc) rd_q[wptr_q[AW-1:0]] <= i_alloc_rd;
  end

  ////////////////////
  // Occupancy and hazard match
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      if (wptr_q[AW] == rptr_q[AW]) begin
        ent_vld[i] = (i >= rptr_q[AW-1:0]) && (i < wptr_q[AW-1:0]);
      end else begin
        ent_vld[i] = (i >= rptr_q[AW-1:0]) || (i < wptr_q[AW-1:0]);  // Wrapped
      end
      ent_match[i] = ent_vld[i] && (rd_q[i] != '0) &&
                     ((i_chk_rs1en && (i_chk_rs1 == rd_q[i])) ||
                      (i_chk_rs2en && (i_chk_rs2 == rd_q[i])) ||
                      (i_chk_rden  && (i_chk_rd  == rd_q[i])));
    end
  end

  assign o_hazard  = |ent_match;
  assign o_head_rd = rd_q[rptr_q[AW-1:0]];
  assign o_empty   = (wptr_q == rptr_q);
  assign o_full    = (wptr_q[AW] != rptr_q[AW]) && (wptr_q[AW-1:0] == rptr_q[AW-1:0]);

endmodule

//--- hdl/exu_disp.sv
/*
  Dispatch
  Holds an instruction back on an OITF hazard, then sends it to the
  ALU or, for a load, to the load unit while allocating an OITF entry
*/
`timescale 1ns/1ns
`include "exu_cfg.svh"

module exu_disp (
  input  logic                      i_valid,
  output logic                      o_ready,
  input  exu_isa_pkg::dec_info_t    i_dec,
  input  logic [`EXU_XLEN-1:0]      i_rs1,
  input  logic [`EXU_XLEN-1:0]      i_rs2,
  input  logic                      i_hazard,
  input  logic                      i_oitf_full,
  output logic                      o_alloc,
  output logic [`EXU_RFIDX_W-1:0]   o_alloc_rd,
  output logic                      o_alu_valid,
  input  logic                      i_alu_ready,
  output exu_pipe_pkg::alu_req_t    o_alu_req,
  output logic                      o_lsu_cmd_valid,
  input  logic                      i_lsu_cmd_ready,
  output exu_pipe_pkg::lsu_cmd_t    o_lsu_cmd
);

  logic is_load;
  logic is_alu;

  assign is_load = i_dec.is_load;
  assign is_alu  = i_dec.rdwen & ~i_dec.is_load;  // Every legal non-load writes rd

  // Illegal opcodes fall through and are simply consumed
  assign o_ready = ~i_hazard & (is_load ? (~i_oitf_full & i_lsu_cmd_ready) :
                                is_alu  ? i_alu_ready : 1'b1);

  ////////////////////
  // Load path
  assign o_lsu_cmd_valid = i_valid & is_load & ~i_hazard & ~i_oitf_full;
  assign o_lsu_cmd.addr  = i_rs1 + i_dec.imm;  // Address adder
  assign o_alloc         = o_lsu_cmd_valid & i_lsu_cmd_ready;
  assign o_alloc_rd      = i_dec.rd;

  ////////////////////
  // ALU path
  assign o_alu_valid      = i_valid & is_alu & ~i_hazard;
  assign o_alu_req.alu_op = i_dec.alu_op;
  assign o_alu_req.opa    = i_rs1;
  assign o_alu_req.opb    = i_dec.use_imm ? i_dec.imm : i_rs2;
  assign o_alu_req.rd     = i_dec.rd;

endmodule

//--- hdl/exu_alu.sv
/*
  Single-cycle ALU
  Add, subtract, and, xor on two operands; the result leaves
  in the same cycle as a write-back request
*/
`timescale 1ns/1ns

module exu_alu (
  input  logic                   i_valid,
  output logic                   o_ready,
  input  exu_pipe_pkg::alu_req_t i_req,
  output logic                   o_valid,
  input  logic                   i_ready,
  output exu_pipe_pkg::wbck_t    o_wbck
);

  // No internal state, so the handshake flows straight through
  assign o_valid = i_valid;
  assign o_ready = i_ready;

  assign o_wbck.rd = i_req.rd;

  always_comb begin
    case (i_req.alu_op)
      exu_isa_pkg::ALU_ADD: o_wbck.wdat = i_req.opa + i_req.opb;
      exu_isa_pkg::ALU_SUB: o_wbck.wdat = i_req.opa - i_req.opb;
      exu_isa_pkg::ALU_AND: o_wbck.wdat = i_req.opa & i_req.opb;
      default:              o_wbck.wdat = i_req.opa ^ i_req.opb;  // XOR
    endcase
  end

endmodule

//--- hdl/exu_wbck.sv
/*
  Final write-back arbiter
  Merges load returns and ALU results onto the single register
  file write port; a load return always wins and retires the
  OITF head
*/
`timescale 1ns/1ns
`include "exu_cfg.svh"

module exu_wbck (
  input  logic                    i_alu_valid,
  output logic                    o_alu_ready,
  input  exu_pipe_pkg::wbck_t     i_alu_wbck,
  input  logic                    i_lsu_rsp_valid,
  output logic                    o_lsu_rsp_ready,
  input  logic [`EXU_XLEN-1:0]    i_lsu_rsp_rdata,
  input  logic [`EXU_RFIDX_W-1:0] i_head_rd,
  output logic                    o_retire,
  output logic                    o_wen,
  output exu_pipe_pkg::wbck_t     o_wbck
);

  // Responses are never stalled
  assign o_lsu_rsp_ready = 1'b1;
  assign o_alu_ready     = ~i_lsu_rsp_valid;  // ALU waits behind a load return

  assign o_retire = i_lsu_rsp_valid;
  assign o_wen    = i_lsu_rsp_valid | i_alu_valid;

  always_comb begin
    if (i_lsu_rsp_valid) begin
      o_wbck.rd   = i_head_rd;  // In order, so the head owns the data
      o_wbck.wdat = i_lsu_rsp_rdata;
    end else begin
      o_wbck = i_alu_wbck;
    end
  end

endmodule

//--- hdl/exu_top.sv
/*
  Execute stage top
  Decode, register file, dispatch, OITF, ALU and write-back
  wired into one in-order integer execute unit
*/
`timescale 1ns/1ns
`include "exu_cfg.svh"

module exu_top (
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  logic                   i_valid,
  output logic                   o_ready,
  input  exu_isa_pkg::instr_t    i_instr,
  output logic                   o_lsu_cmd_valid,
  input  logic                   i_lsu_cmd_ready,
  output exu_pipe_pkg::lsu_cmd_t o_lsu_cmd,
  input  logic                   i_lsu_rsp_valid,
  output logic                   o_lsu_rsp_ready,
  input  logic [`EXU_XLEN-1:0]   i_lsu_rsp_rdata,
  output logic                   o_wbck_valid,
  output exu_pipe_pkg::wbck_t    o_wbck,
  output logic                   o_oitf_empty
);

  exu_isa_pkg::dec_info_t  dec;
  logic [`EXU_XLEN-1:0]    rf_rs1;
  logic [`EXU_XLEN-1:0]    rf_rs2;
  logic                    oitf_hazard;
  logic                    oitf_full;
  logic                    oitf_alloc;
  logic [`EXU_RFIDX_W-1:0] oitf_alloc_rd;
  logic                    oitf_retire;
  logic [`EXU_RFIDX_W-1:0] oitf_head_rd;
  logic                    disp_alu_valid;
  logic                    disp_alu_ready;
  exu_pipe_pkg::alu_req_t  disp_alu_req;
  logic                    alu_wbck_valid;
  logic                    alu_wbck_ready;
  exu_pipe_pkg::wbck_t     alu_wbck;

  exu_decode u_decode (.i_instr(i_instr), .o_dec(dec));

  exu_regfile u_regfile (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_rs1idx (dec.rs1),
    .i_rs2idx (dec.rs2),
    .i_wen    (o_wbck_valid),   // Same pulse as the outside write-back
    .i_wbck   (o_wbck),
    .o_rs1    (rf_rs1),
    .o_rs2    (rf_rs2)
  );

  ////////////////////
  // Dispatch and OITF
  exu_disp u_disp (
    .i_valid         (i_valid),
    .o_ready         (o_ready),
    .i_dec           (dec),
    .i_rs1           (rf_rs1),
    .i_rs2           (rf_rs2),
    .i_hazard        (oitf_hazard),
    .i_oitf_full     (oitf_full),
    .o_alloc         (oitf_alloc),
    .o_alloc_rd      (oitf_alloc_rd),
    .o_alu_valid     (disp_alu_valid),
    .i_alu_ready     (disp_alu_ready),
    .o_alu_req       (disp_alu_req),
    .o_lsu_cmd_valid (o_lsu_cmd_valid),
    .i_lsu_cmd_ready (i_lsu_cmd_ready),
    .o_lsu_cmd       (o_lsu_cmd)
  );

  exu_oitf u_oitf (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_alloc     (oitf_alloc),
    .i_alloc_rd  (oitf_alloc_rd),
    .i_retire    (oitf_retire),
    .i_chk_rs1   (dec.rs1),
    .i_chk_rs2   (dec.rs2),
    .i_chk_rd    (dec.rd),
    .i_chk_rs1en (dec.rs1en),
    .i_chk_rs2en (dec.rs2en),
    .i_chk_rden  (dec.rdwen),
    .o_hazard    (oitf_hazard),
    .o_head_rd   (oitf_head_rd),
    .o_full      (oitf_full),
    .o_empty     (o_oitf_empty)
  );

  ////////////////////
  // Execute and write-back
  exu_alu u_alu (
    .i_valid (disp_alu_valid),
    .o_ready (disp_alu_ready),
    .i_req   (disp_alu_req),
    .o_valid (alu_wbck_valid),
    .i_ready (alu_wbck_ready),
    .o_wbck  (alu_wbck)
  );

  exu_wbck u_wbck (
    .i_alu_valid     (alu_wbck_valid),
    .o_alu_ready     (alu_wbck_ready),
    .i_alu_wbck      (alu_wbck),
    .i_lsu_rsp_valid (i_lsu_rsp_valid),
    .o_lsu_rsp_ready (o_lsu_rsp_ready),
    .i_lsu_rsp_rdata (i_lsu_rsp_rdata),
    .i_head_rd       (oitf_head_rd),
    .o_retire        (oitf_retire),
    .o_wen           (o_wbck_valid),
    .o_wbck          (o_wbck)
  );

endmodule

//--- tests/exu_tb.sv
/*
  Execute unit testbench
  Directed and random instruction streams against a reference
  register model, with a load-unit model that answers in order
  after random delays
*/
`timescale 1ns/1ns
`include "exu_cfg.svh"

module exu_tb;

  localparam int          SEED     = 45912;
  localparam int          TMO      = 200;          // Cycles per wait loop
  localparam int          DEPTH    = `EXU_OITF_DEPTH;
  localparam logic [31:0] LOAD_PAT = 32'hc3a5_5a3c;

  logic                   clk;
  logic                   i_arst_n;
  logic                   i_valid;
  logic                   o_ready;
  exu_isa_pkg::instr_t    i_instr;
  logic                   o_lsu_cmd_valid;
  logic                   i_lsu_cmd_ready;
  exu_pipe_pkg::lsu_cmd_t o_lsu_cmd;
  logic                   i_lsu_rsp_valid;
  logic                   o_lsu_rsp_ready;
  logic [`EXU_XLEN-1:0]   i_lsu_rsp_rdata;
  logic                   o_wbck_valid;
  exu_pipe_pkg::wbck_t    o_wbck;
  logic                   o_oitf_empty;

  ////////////////////
  // Reference model state
  logic [`EXU_XLEN-1:0]    ref_rf [32];
  logic [`EXU_RFIDX_W-1:0] pend_rd [DEPTH];   // Loads in flight with the oldest first
  logic [`EXU_XLEN-1:0]    pend_dat [DEPTH];
  int                      pend_cnt;
  logic [`EXU_XLEN-1:0]    cmd_q [$];         // Addresses seen by the load unit
  logic                    took;
  logic                    rsp_hold;
  integer                  seed = SEED;
  integer                  rsp_seed = SEED;

  logic [2:0]              op;
  logic                    is_ld;
  logic                    is_alu;
  logic                    rs1en;
  logic                    rs2en;
  logic                    rden;
  logic                    hz;
  logic                    exp_ready;
  logic                    acc;
  logic                    exp_wb_valid;
  logic [`EXU_XLEN-1:0]    opa;
  logic [`EXU_XLEN-1:0]    opb;
  logic [`EXU_XLEN-1:0]    imm_x;
  logic [`EXU_XLEN-1:0]    alu_res;
  logic [`EXU_XLEN-1:0]    ld_addr;
  exu_pipe_pkg::wbck_t     exp_wbck;

  exu_top DUT (.*);

  initial begin : clock_gen
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // Expected responses for the current cycle
  always_comb begin
    op     = i_instr.opcode;
    is_ld  = (op == exu_isa_pkg::OP_LOAD);
    is_alu = (op <= exu_isa_pkg::OP_ADDI);
    rs1en  = is_alu || is_ld;
    rs2en  = (op <= exu_isa_pkg::OP_XOR);  // Register-register forms only
    rden   = rs1en;
    imm_x  = $signed(i_instr.imm);
    opa    = (i_instr.rs1 == '0) ? '0 : ref_rf[i_instr.rs1];
    opb    = (op == exu_isa_pkg::OP_ADDI) ? imm_x :
             (i_instr.rs2 == '0) ? '0 : ref_rf[i_instr.rs2];
    case (op)
      exu_isa_pkg::OP_SUB: alu_res = opa - opb;
      exu_isa_pkg::OP_AND: alu_res = opa & opb;
      exu_isa_pkg::OP_XOR: alu_res = opa ^ opb;
      default:             alu_res = opa + opb;
    endcase
    ld_addr = opa + imm_x;

    hz = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      if (i < pend_cnt && pend_rd[i] != '0 &&
          ((rs1en && pend_rd[i] == i_instr.rs1) || (rs2en && pend_rd[i] == i_instr.rs2) ||
           (rden && pend_rd[i] == i_instr.rd))) begin
        hz = 1'b1;
      end
    end
    if (hz)          exp_ready = 1'b0;
    else if (is_ld)  exp_ready = (pend_cnt < DEPTH) && i_lsu_cmd_ready;
    else if (is_alu) exp_ready = !i_lsu_rsp_valid;  // Load return owns the write port
    else             exp_ready = 1'b1;
    acc = i_valid && exp_ready;

    exp_wb_valid = i_lsu_rsp_valid || (acc && is_alu);
    if (i_lsu_rsp_valid) begin
      exp_wbck.rd   = pend_rd[0];
      exp_wbck.wdat = pend_dat[0];
    end else begin
      exp_wbck.rd   = i_instr.rd;
      exp_wbck.wdat = alu_res;
    end
  end

  always @(posedge clk or negedge i_arst_n) begin : model_update
    int n;
    if (!i_arst_n) begin
      for (int i = 0; i < 32; i++) begin
        ref_rf[i] <= '0;
      end
      pend_cnt <= 0;
      took     <= 1'b0;
    end else begin
      took <= i_valid && o_ready;
      if (exp_wb_valid && exp_wbck.rd != '0) ref_rf[exp_wbck.rd] <= exp_wbck.wdat;
      n = pend_cnt;
      if (i_lsu_rsp_valid) begin
        pend_rd[0]  <= pend_rd[1];
        pend_dat[0] <= pend_dat[1];
        n = n - 1;
      end
      if (acc && is_ld) begin
        pend_rd[n]  <= i_instr.rd;
        pend_dat[n] <= ld_addr ^ LOAD_PAT;
        n = n + 1;
      end
      pend_cnt <= n;
      if (o_lsu_cmd_valid && i_lsu_cmd_ready) cmd_q.push_back(o_lsu_cmd.addr);
    end
  end

  // Load unit model answers in command order
  initial begin : lsu_responder
    int dly;
    forever begin
      @(negedge clk);
      if (!rsp_hold && cmd_q.size() > 0) begin
        dly = $unsigned($random(rsp_seed)) % 6;
        repeat (dly) @(negedge clk);
        i_lsu_rsp_valid = 1'b1;
        i_lsu_rsp_rdata = cmd_q.pop_front() ^ LOAD_PAT;
        @(negedge clk);
        i_lsu_rsp_valid = 1'b0;
      end
    end
  end

  ////////////////////
  // Checks
  task automatic stop_with_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    stop_with_failure();
  endtask

  ready_rule: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_valid |-> (o_ready == exp_ready))
    else report_mismatch("o_ready", $sampled(o_ready), $sampled(exp_ready));
  wbck_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_wbck_valid == exp_wb_valid)
    else report_mismatch("o_wbck_valid", $sampled(o_wbck_valid), $sampled(exp_wb_valid));
  wbck_rd: assert property (@(posedge clk) disable iff (!i_arst_n)
    exp_wb_valid |-> (o_wbck.rd == exp_wbck.rd))
    else report_mismatch("o_wbck.rd", $sampled(o_wbck.rd), $sampled(exp_wbck.rd));
  wbck_data: assert property (@(posedge clk) disable iff (!i_arst_n)
    exp_wb_valid |-> (o_wbck.wdat == exp_wbck.wdat))
    else report_mismatch("o_wbck.wdat", $sampled(o_wbck.wdat), $sampled(exp_wbck.wdat));
  load_addr: assert property (@(posedge clk) disable iff (!i_arst_n)
    (acc && is_ld) |-> (o_lsu_cmd_valid && o_lsu_cmd.addr == ld_addr))
    else report_mismatch("o_lsu_cmd.addr", $sampled(o_lsu_cmd.addr), $sampled(ld_addr));
  load_cmd_only: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_lsu_cmd_valid && i_lsu_cmd_ready) |-> (acc && is_ld))
    else report_mismatch("o_lsu_cmd_valid", $sampled(o_lsu_cmd_valid), 0);
  oitf_empty_state: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_oitf_empty == (pend_cnt == 0))
    else report_mismatch("o_oitf_empty", $sampled(o_oitf_empty), $sampled(pend_cnt == 0));
  rsp_always_ready: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_lsu_rsp_ready)
    else report_mismatch("o_lsu_rsp_ready", $sampled(o_lsu_rsp_ready), 1);

  ////////////////////
  // Stimulus helpers
  function automatic exu_isa_pkg::instr_t make_instr(input exu_isa_pkg::opcode_e opc,
      input int rd, input int rs1, input int rs2, input int imm);
    exu_isa_pkg::instr_t ins;
    ins.opcode = opc;
    ins.rd     = rd[`EXU_RFIDX_W-1:0];
    ins.rs1    = rs1[`EXU_RFIDX_W-1:0];
    ins.rs2    = rs2[`EXU_RFIDX_W-1:0];
    ins.imm    = imm[`EXU_IMM_W-1:0];
    return ins;
  endfunction

  // Every field random, so illegal codes 6 and 7 show up too
  function automatic exu_isa_pkg::instr_t rand_instr();
    return exu_isa_pkg::instr_t'($random(seed));
  endfunction

  task automatic send(input exu_isa_pkg::instr_t ins);
    int n;
    n = 0;
    i_valid = 1'b1;
    i_instr = ins;
    do begin
      @(negedge clk);
      n++;
    end while (!took && n < TMO);
    if (!took) begin
      $display("Timeout: instruction 0x%h not accepted after %0d cycles", ins, TMO);
      stop_with_failure();
    end
    i_valid = 1'b0;
  endtask

  // Presents an instruction that must stay stalled
  task automatic hold_off(input exu_isa_pkg::instr_t ins, input int cycles);
    i_valid = 1'b1;
    i_instr = ins;
    repeat (cycles) @(negedge clk);
    i_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!o_oitf_empty && n < TMO);
    if (!o_oitf_empty) begin
      $display("Timeout: loads still outstanding after %0d cycles", TMO);
      stop_with_failure();
    end
  endtask

  initial begin : stimulus
    i_arst_n        = 1'b0;
    i_valid         = 1'b0;
    i_instr         = '0;
    i_lsu_cmd_ready = 1'b1;
    i_lsu_rsp_valid = 1'b0;
    i_lsu_rsp_rdata = '0;
    rsp_hold        = 1'b0;
    repeat (10) @(negedge clk);
    i_arst_n = 1'b1;
    @(negedge clk);

    send(make_instr(exu_isa_pkg::OP_ADD, 3, 7, 9, 0));  // All zero after reset
    for (int r = 1; r < 32; r++) begin
      send(make_instr(exu_isa_pkg::OP_ADDI, r, 0, 0, $random(seed)));
    end

    // x0 write shows up but is not kept
    send(make_instr(exu_isa_pkg::OP_ADDI, 0, 4, 0, 'h155));
    send(make_instr(exu_isa_pkg::OP_XOR, 2, 0, 0, 0));

    for (int k = 0; k < 400; k++) begin
      send(rand_instr());
    end
    wait_drain();

    ////////////////////
    // Hazards and a full OITF, load unit held back
    rsp_hold = 1'b1;
    send(make_instr(exu_isa_pkg::OP_LOAD, 5, 1, 0, 16));
    hold_off(make_instr(exu_isa_pkg::OP_ADD, 6, 5, 2, 0), 3);
    hold_off(make_instr(exu_isa_pkg::OP_SUB, 6, 2, 5, 0), 3);
    hold_off(make_instr(exu_isa_pkg::OP_ADDI, 5, 2, 0, 1), 3);
    send(make_instr(exu_isa_pkg::OP_LOAD, 7, 2, 0, -8));
    hold_off(make_instr(exu_isa_pkg::OP_LOAD, 8, 3, 0, 4), 3);  // Third load
    rsp_hold = 1'b0;
    send(make_instr(exu_isa_pkg::OP_LOAD, 8, 3, 0, 4));
    send(make_instr(exu_isa_pkg::OP_ADD, 6, 5, 7, 0));
    wait_drain();

    // Load return lands inside a burst of independent ALU ops
    send(make_instr(exu_isa_pkg::OP_LOAD, 9, 4, 0, 32));
    for (int j = 0; j < 8; j++) begin
      send(make_instr(exu_isa_pkg::OP_ADD, 10 + j, 11 + j, 20 + j, 0));
    end
    wait_drain();

    repeat (2) @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- build.f
+incdir+hdl
hdl/exu_isa_pkg.sv
hdl/exu_pipe_pkg.sv
hdl/exu_regfile.sv
hdl/exu_decode.sv
hdl/exu_oitf.sv
hdl/exu_disp.sv
hdl/exu_alu.sv
hdl/exu_wbck.sv
hdl/exu_top.sv
tests/exu_tb.sv
